/* common/configure.sv */
package configure;

  // Bus widths
  localparam int data_width = 32;
  localparam int addr_width = 32;
  localparam int strb_width = data_width / 8;

  // Byte offset inside one bus word
  localparam int byte_offset_bits = $clog2(strb_width);

  // SRAM geometry and access timing
  localparam int sram_depth_log2 = 10;
  localparam int sram_words = 1 << sram_depth_log2;
  localparam int sram_wait_cycles = 2;

  // Wide enough to hold sram_wait_cycles, never zero bits
  localparam int sram_wait_width = $clog2(sram_wait_cycles + 2);
  localparam logic [sram_wait_width-1:0] sram_wait_last = sram_wait_width'(sram_wait_cycles);

  // AHB transfer types
  localparam logic [1:0] htrans_idle = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  // Bridge FSM encoding
  localparam logic [1:0] state_idle = 2'd0;
  localparam logic [1:0] state_load = 2'd1;
  localparam logic [1:0] state_store = 2'd2;

  // Core memory port, zero strobe means load
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic [data_width-1:0] rdata;
    logic                  ready;
  } cpu_rsp_t;

  // Master to slave
  typedef struct packed {
    logic [addr_width-1:0] haddr;
    logic [data_width-1:0] hwdata;
    logic [strb_width-1:0] hwstrb;
    logic                  hwrite;
    logic [1:0]            htrans;
  } ahb_m2s_t;

  // Slave to master
  typedef struct packed {
    logic [data_width-1:0] hrdata;
    logic                  hready;
  } ahb_s2m_t;

endpackage

/* hdl/ahb_master_bridge.sv */
`timescale 1ns/1ps

module ahb_master_bridge (
  input  logic                clock,
  input  logic                reset,
  input  configure::cpu_req_t cpu_req,
  output configure::cpu_rsp_t cpu_rsp,
  output configure::ahb_m2s_t bus_out,
  input  configure::ahb_s2m_t bus_in
);

  logic [1:0] state;
  logic [1:0] state_reg;

  logic [configure::addr_width-1:0] haddr;
  logic [configure::addr_width-1:0] haddr_reg;
  logic [configure::data_width-1:0] hwdata;
  logic [configure::data_width-1:0] hwdata_reg;
  logic [configure::strb_width-1:0] hwstrb;
  logic [configure::strb_width-1:0] hwstrb_reg;
  logic                             hwrite;
  logic                             hwrite_reg;
  logic [1:0]                       htrans;
  logic [1:0]                       htrans_reg;

  logic [configure::data_width-1:0] rdata;
  logic [configure::data_width-1:0] rdata_reg;
  logic                             ready;
  logic                             ready_reg;

  logic [configure::addr_width-1:0] aligned_addr;
  logic                             is_store;

  // Byte offset dropped, the slave works on whole words
  assign aligned_addr = {cpu_req.addr[configure::addr_width-1:configure::byte_offset_bits],
                         {configure::byte_offset_bits{1'b0}}};
  assign is_store = |cpu_req.wstrb;

  always_comb begin
    state = state_reg;
    haddr = '0;
    hwdata = '0;
    hwstrb = '0;
    hwrite = 1'b0;
    htrans = configure::htrans_idle;
    rdata = '0;
    ready = 1'b0;
    case (state_reg)
      configure::state_idle: begin
        if (cpu_req.valid) begin
          haddr = aligned_addr;
          htrans = configure::htrans_nonseq;
          if (is_store) begin
            state = configure::state_store;
            hwdata = cpu_req.wdata;
            hwstrb = cpu_req.wstrb;
            hwrite = 1'b1;
          end else begin
            state = configure::state_load;
          end
        end
      end
      configure::state_load: begin
        if (bus_in.hready) begin
          state = configure::state_idle;
          rdata = bus_in.hrdata;
          ready = 1'b1;
        end else begin
          haddr = haddr_reg;
          htrans = htrans_reg;
        end
      end
      configure::state_store: begin
        if (bus_in.hready) begin
          state = configure::state_idle;
          ready = 1'b1;
        end else begin
          // Hold the whole write while the slave stalls
          haddr = haddr_reg;
          hwdata = hwdata_reg;
          hwstrb = hwstrb_reg;
          hwrite = hwrite_reg;
          htrans = htrans_reg;
        end
      end
      default: begin
        state = configure::state_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_reg <= configure::state_idle;
      haddr_reg <= '0;
      hwdata_reg <= '0;
      hwstrb_reg <= '0;
      hwrite_reg <= 1'b0;
      htrans_reg <= configure::htrans_idle;
      rdata_reg <= '0;
      ready_reg <= 1'b0;
    end else begin
      state_reg <= state;
      haddr_reg <= haddr;
      hwdata_reg <= hwdata;
      hwstrb_reg <= hwstrb;
      hwrite_reg <= hwrite;
      htrans_reg <= htrans;
      rdata_reg <= rdata;
      ready_reg <= ready;
    end
  end

  // Bus side
  assign bus_out.haddr = haddr_reg;
  assign bus_out.hwdata = hwdata_reg;
  assign bus_out.hwstrb = hwstrb_reg;
  assign bus_out.hwrite = hwrite_reg;
  assign bus_out.htrans = htrans_reg;

  // Core side
  assign cpu_rsp.rdata = rdata_reg;
  assign cpu_rsp.ready = ready_reg;

endmodule

/* hdl/ahb_sram_slave.sv */
`timescale 1ns/1ps

module ahb_sram_slave (
  input  logic                clock,
  input  logic                reset,
  input  configure::ahb_m2s_t bus_in,
  output configure::ahb_s2m_t bus_out
);

  logic [configure::data_width-1:0] mem [configure::sram_words];

  logic [configure::sram_wait_width-1:0] wait_count;
  logic [configure::sram_depth_log2-1:0] word_index;
  logic                                  active;
  logic                                  complete;
  logic                                  write_en;
  logic                                  read_en;

  // Upper address bits are ignored so accesses wrap around the array
  assign word_index = bus_in.haddr[configure::byte_offset_bits +: configure::sram_depth_log2];

  assign active = bus_in.htrans == configure::htrans_nonseq;
  assign complete = active && (wait_count == configure::sram_wait_last);
  assign write_en = complete && bus_in.hwrite;
  assign read_en = complete && !bus_in.hwrite;

  // Wait states of the current transfer
  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_count <= '0;
    end else if (!active || complete) begin
      wait_count <= '0;
    end else begin
      wait_count <= wait_count + 1'b1;
    end
  end

  // Byte lanes are written independently
  always_ff @(posedge clock) begin
    if (write_en) begin
      for (int lane = 0; lane < configure::strb_width; lane++) begin
        if (bus_in.hwstrb[lane]) begin
          mem[word_index][8*lane +: 8] <= bus_in.hwdata[8*lane +: 8];
        end
      end
    end
  end

  // Idle bus sees the slave as ready
  assign bus_out.hready = !active || complete;
  assign bus_out.hrdata = read_en ? mem[word_index] : '0;

endmodule

/* hdl/ahb_memory_subsystem.sv */
`timescale 1ns/1ps

module ahb_memory_subsystem (
  input  logic                clock,
  input  logic                reset,
  input  configure::cpu_req_t cpu_req,
  output configure::cpu_rsp_t cpu_rsp
);

  configure::ahb_m2s_t ahb_m2s;
  configure::ahb_s2m_t ahb_s2m;

  ahb_master_bridge ahb_master_bridge_i (
    .clock   (clock),
    .reset   (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .bus_out (ahb_m2s),
    .bus_in  (ahb_s2m)
  );

  // Single slave, no decoder needed
  ahb_sram_slave ahb_sram_slave_i (
    .clock   (clock),
    .reset   (reset),
    .bus_in  (ahb_m2s),
    .bus_out (ahb_s2m)
  );

endmodule

/* testbench/ahb_memory_checker.sv */
`timescale 1ns/1ps

module ahb_memory_checker (
  input  logic                clock,
  input  logic                reset,
  input  configure::cpu_req_t cpu_req,
  input  configure::cpu_rsp_t cpu_rsp,
  output int                  mismatch_count
);

  localparam int latency = configure::sram_wait_cycles + 2;

  logic [configure::data_width-1:0] model [configure::sram_words];

  int                               cycle_count;
  int                               accept_cycle;
  bit                               busy;
  bit                               pending_load;
  logic [configure::data_width-1:0] expected;

  initial begin
    mismatch_count = 0;
    busy = 1'b0;
    cycle_count = 0;
  end

  always @(posedge clock) begin : compare
    logic [configure::sram_depth_log2-1:0] idx;

    idx = cpu_req.addr[configure::byte_offset_bits +: configure::sram_depth_log2];
    if (!reset) begin
      busy = 1'b0;
      cycle_count = 0;
    end else begin
      cycle_count++;

      // Completion first, a new request may share the ready cycle
      if (cpu_rsp.ready) begin
        if (!busy) begin
          $display("Ready was raised with no request outstanding at cycle %0d", cycle_count);
          mismatch_count++;
        end else begin
          if (cycle_count - accept_cycle != latency) begin
            $display("MISMATCH latency expected %0d actual %0d",
                     latency, cycle_count - accept_cycle);
            mismatch_count++;
          end
          if (pending_load && cpu_rsp.rdata !== expected) begin
            $display("MISMATCH read_data expected %08h actual %08h",
                     expected, cpu_rsp.rdata);
            mismatch_count++;
          end
          busy = 1'b0;
        end
      end else if (busy && cycle_count - accept_cycle > latency) begin
        $display("MISMATCH latency expected %0d actual %0d",
                 latency, cycle_count - accept_cycle);
        mismatch_count++;
        busy = 1'b0;
      end

      if (cpu_req.valid && !busy) begin
        busy = 1'b1;
        accept_cycle = cycle_count;
        pending_load = cpu_req.wstrb == '0;
        if (pending_load) begin
          expected = model[idx];
        end else begin
          for (int lane = 0; lane < configure::strb_width; lane++) begin
            if (cpu_req.wstrb[lane]) begin
              model[idx][8*lane +: 8] = cpu_req.wdata[8*lane +: 8];
            end
          end
        end
      end
    end
  end

endmodule

/* testbench/ahb_memory_properties.sv */
`timescale 1ns/1ps

module ahb_memory_properties (
  input logic                clock,
  input logic                reset,
  input configure::cpu_rsp_t cpu_rsp,
  input configure::ahb_m2s_t bus_out,
  input configure::ahb_s2m_t bus_in
);

  // A stalled transfer keeps every field
  assert property (@(posedge clock) disable iff (!reset)
    (bus_out.htrans == configure::htrans_nonseq && !bus_in.hready) |=> $stable(bus_out))
    else $error("Bus fields changed while the slave was stalling");

  assert property (@(posedge clock) disable iff (!reset)
    cpu_rsp.ready |=> !cpu_rsp.ready)
    else $error("Ready stayed high for more than one cycle");

  assert property (@(posedge clock) disable iff (!reset)
    bus_out.haddr[configure::byte_offset_bits-1:0] == '0)
    else $error("Bus address is not word aligned");

endmodule

bind ahb_master_bridge ahb_memory_properties properties_i (
  .clock   (clock),
  .reset   (reset),
  .cpu_rsp (cpu_rsp),
  .bus_out (bus_out),
  .bus_in  (bus_in)
);

/* testbench/ahb_memory_tb.sv */
`timescale 1ns/1ps

module ahb_memory_tb;

  localparam int transaction_count = 400;
  localparam int ready_timeout = 50;
  localparam int latency = configure::sram_wait_cycles + 2;

  logic                clock;
  logic                reset;
  configure::cpu_req_t cpu_req;
  configure::cpu_rsp_t cpu_rsp;

  int          mismatch_count;
  int          timeout_count;
  logic [31:0] rng;
  logic        written [configure::sram_words];
  int          written_q [$];

  always #50 clock = ~clock;

  ahb_memory_subsystem ahb_memory_subsystem_i (
    .clock   (clock),
    .reset   (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp)
  );

  ahb_memory_checker checker_i (
    .clock          (clock),
    .reset          (reset),
    .cpu_req        (cpu_req),
    .cpu_rsp        (cpu_rsp),
    .mismatch_count (mismatch_count)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Samples just after the edge, where ready is settled
  task automatic wait_for_ready(output bit ok);
    ok = 1'b0;
    for (int cycle = 0; cycle < ready_timeout && !ok; cycle++) begin
      @(posedge clock);
      #1;
      if (cpu_rsp.ready) begin
        ok = 1'b1;
      end
    end
  endtask

  initial begin
    configure::cpu_req_t                     req;
    logic [configure::sram_depth_log2-1:0]  idx;
    logic [configure::byte_offset_bits-1:0] low;
    bit                                      chained;
    bit                                      ok;
    bit                                      stop;
    int                                      pick;

    clock = 1'b0;
    reset <= 1'b0;
    cpu_req <= '0;
    rng = 32'd10;
    timeout_count = 0;
    stop = 1'b0;
    for (int i = 0; i < configure::sram_words; i++) begin
      written[i] = 1'b0;
    end

    repeat (10) @(posedge clock);
    reset <= 1'b1;
    // Idle stretch, ready must stay low here
    repeat (5) @(posedge clock);

    for (int n = 0; n < transaction_count && !stop; n++) begin
      rng = xorshift(rng);
      chained = rng[30];
      low = rng[20 +: configure::byte_offset_bits];
      req = '0;
      req.valid = 1'b1;
      req.wdata = xorshift(rng ^ 32'h5a5a_1234);
      if (rng[31] && written_q.size() > 0) begin
        pick = int'(rng[15:0]) % written_q.size();
        idx = written_q[pick][configure::sram_depth_log2-1:0];
        req.wstrb = '0;
      end else begin
        idx = rng[configure::sram_depth_log2-1:0];
        req.wstrb = rng[24 +: configure::strb_width];
        // First write of a word covers all bytes so no lane stays unknown
        if (req.wstrb == '0 || !written[idx]) begin
          req.wstrb = '1;
        end
        if (!written[idx]) begin
          written[idx] = 1'b1;
          written_q.push_back(int'(idx));
        end
      end
      req.addr = configure::addr_width'({idx, low});

      cpu_req <= req;
      @(posedge clock);
      cpu_req.valid <= 1'b0;

      if (chained) begin
        // Next request lands on the ready edge of this one
        for (int cycle = 0; cycle < latency - 1; cycle++) begin
          @(posedge clock);
        end
      end else begin
        wait_for_ready(ok);
        if (!ok) begin
          $display("Timeout: ready never came back for request %0d", n);
          timeout_count++;
          stop = 1'b1;
        end
        @(posedge clock);
      end
    end

    repeat (latency + 3) @(posedge clock);

    $display("Mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
common/configure.sv
hdl/ahb_master_bridge.sv
hdl/ahb_sram_slave.sv
hdl/ahb_memory_subsystem.sv
testbench/ahb_memory_checker.sv
testbench/ahb_memory_properties.sv
testbench/ahb_memory_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ahb_memory_tb \
  -f build.f -o ahb_memory_sim > build.log 2>&1 &&
./obj_dir/ahb_memory_sim > sim.log 2>&1 ;
grep -q "^No errors$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
